/* common/issue_pkg.sv */
// issue slot definitions
package issue_pkg;

    localparam int reg_idx_width = 5;

    // index of the hardwired zero register
    localparam logic [reg_idx_width-1:0] reg_zero = '0;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_or,
        op_and,
        op_load,
        op_store,
        op_branch,
        op_syscall,
        op_break
    } opcode_e;

    // one decoded instruction
    typedef struct packed {
        logic [31:0]              pc;
        opcode_e                  op;
        logic [reg_idx_width-1:0] rd;
        logic [reg_idx_width-1:0] rj;
        logic [reg_idx_width-1:0] rk;
        logic [31:0]              imm;
        logic                     excp;
        logic                     pred_taken; // only meaningful for branches
    } slot_t;

    localparam slot_t nop_slot = '{
        pc:         32'h0,
        op:         op_nop,
        rd:         '0,
        rj:         '0,
        rk:         '0,
        imm:        32'h0,
        excp:       1'b0,
        pred_taken: 1'b0
    };

    // simple ops that either lane can execute
    function automatic logic is_alu(opcode_e op);
        return op inside {op_add, op_sub, op_or, op_and};
    endfunction

endpackage

/* common/ctrl_pkg.sv */
// issue control definitions
package ctrl_pkg;

    // bundle counter and host data width
    localparam int cnt_width = 16;

    // host register map
    typedef enum logic [1:0] {
        addr_mode       = 2'd0,
        addr_dual_cnt   = 2'd1,
        addr_single_cnt = 2'd2
    } cfg_addr_e;

    // splitter progress through a held pair
    typedef enum logic {
        st_first,
        st_second
    } split_state_e;

endpackage

/* common/pair_if.sv */
// decoded pair link
interface pair_if;

    logic              valid;
    issue_pkg::slot_t  slot0;
    issue_pkg::slot_t  slot1;
    logic              allowin; // consumer can take the pair

    // producer side
    modport src (
        output valid,
        output slot0,
        output slot1,
        input  allowin
    );

    // consumer side
    modport dst (
        input  valid,
        input  slot0,
        input  slot1,
        output allowin
    );

endinterface

/* issue/pair_reg.sv */
// decode to issue pair register
module pair_reg (
    input  logic clk,
    input  logic rstn,
    input  logic flush,
    pair_if.dst  in,
    pair_if.src  out
);

    logic             full;
    logic             load;
    issue_pkg::slot_t slot0_q;
    issue_pkg::slot_t slot1_q;

    // room when empty or when the held pair leaves this cycle
    assign in.allowin = !flush && (!full || out.allowin);
    assign load       = in.valid && in.allowin;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out.allowin) begin
            full <= 1'b0; // consumed, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            slot0_q <= in.slot0;
            slot1_q <= in.slot1;
        end
    end

    assign out.valid = full;
    assign out.slot0 = slot0_q;
    assign out.slot1 = slot1_q;

endmodule

/* issue/dual_issue_split.sv */
// dual issue splitter
module dual_issue_split (
    input  logic             clk,
    input  logic             rstn,
    input  logic             flush,
    input  logic             force_single,
    input  logic             iss_allowin,
    pair_if.dst              held,
    output logic             iss_valid0,
    output logic             iss_valid1,
    output issue_pkg::slot_t iss_slot0,
    output issue_pkg::slot_t iss_slot1,
    output logic             bundle_dual,
    output logic             bundle_single
);

    ctrl_pkg::split_state_e state;

    logic issue_en;
    logic hazard;
    logic pairable;
    logic drop1;
    logic dual;
    logic accept;
    logic last;

    // slot 1 reads what slot 0 writes
    assign hazard = (held.slot0.rd != issue_pkg::reg_zero) &&
                    ((held.slot1.rj == held.slot0.rd) ||
                     (held.slot1.rk == held.slot0.rd));

    assign pairable = issue_pkg::is_alu(held.slot0.op) &&
                      issue_pkg::is_alu(held.slot1.op) &&
                      !held.slot0.excp && !held.slot1.excp &&
                      !hazard;

    // taken branch in slot 0, slot 1 is wrong path
    assign drop1 = (held.slot0.op == issue_pkg::op_branch) && held.slot0.pred_taken;

    assign dual = (state == ctrl_pkg::st_first) && pairable && !force_single && !drop1;

    // nothing goes out in a flush cycle
    assign issue_en = held.valid && !flush;

    always_comb begin
        iss_valid0 = issue_en;
        iss_valid1 = 1'b0;
        iss_slot0  = issue_pkg::nop_slot;
        iss_slot1  = issue_pkg::nop_slot;
        if (issue_en) begin
            if (state == ctrl_pkg::st_second) begin
                iss_slot0 = held.slot1; // second half always on lane 0
            end else begin
                iss_slot0 = held.slot0;
                if (dual) begin
                    iss_valid1 = 1'b1;
                    iss_slot1  = held.slot1;
                end
            end
        end
    end

    assign accept = iss_valid0 && iss_allowin;

    // final bundle of the held pair
    assign last = (state == ctrl_pkg::st_second) || dual || drop1;

    assign held.allowin = accept && last;

    assign bundle_dual   = accept && iss_valid1;
    assign bundle_single = accept && !iss_valid1;

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            state <= ctrl_pkg::st_first;
        end else if (accept) begin
            if (last) begin
                state <= ctrl_pkg::st_first;
            end else begin
                state <= ctrl_pkg::st_second; // slot 1 still pending
            end
        end
    end

endmodule

/* issue/issue_ctrl_regs.sv */
// issue control registers
module issue_ctrl_regs (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           bundle_dual,
    input  logic                           bundle_single,
    input  logic                           cfg_req,
    input  logic                           cfg_we,
    input  ctrl_pkg::cfg_addr_e            cfg_addr,
    input  logic [ctrl_pkg::cnt_width-1:0] cfg_wdata,
    output logic                           cfg_ack,
    output logic [ctrl_pkg::cnt_width-1:0] cfg_rdata,
    output logic                           force_single
);

    logic                           start;
    logic                           wr;
    logic [ctrl_pkg::cnt_width-1:0] dual_cnt;
    logic [ctrl_pkg::cnt_width-1:0] single_cnt;
    logic [ctrl_pkg::cnt_width-1:0] rd_mux;

    // new request, ack not yet given
    assign start = cfg_req && !cfg_ack;
    assign wr    = start && cfg_we;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg_ack <= 1'b0;
        end else if (start) begin
            cfg_ack <= 1'b1;
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            force_single <= 1'b0;
        end else if (wr && cfg_addr == ctrl_pkg::addr_mode) begin
            force_single <= cfg_wdata[0];
        end
    end

    // saturating counters, a write clears
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dual_cnt   <= '0;
            single_cnt <= '0;
        end else begin
            if (wr && cfg_addr == ctrl_pkg::addr_dual_cnt) begin
                dual_cnt <= '0;
            end else if (bundle_dual && dual_cnt != '1) begin
                dual_cnt <= dual_cnt + 1'b1;
            end
            if (wr && cfg_addr == ctrl_pkg::addr_single_cnt) begin
                single_cnt <= '0;
            end else if (bundle_single && single_cnt != '1) begin
                single_cnt <= single_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            ctrl_pkg::addr_mode:       rd_mux = {{(ctrl_pkg::cnt_width-1){1'b0}}, force_single};
            ctrl_pkg::addr_dual_cnt:   rd_mux = dual_cnt;
            ctrl_pkg::addr_single_cnt: rd_mux = single_cnt;
            default:                   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start && !cfg_we) begin
            cfg_rdata <= rd_mux; // held until next read
        end
    end

endmodule

/* source/issue_top.sv */
// dual issue stage top
module issue_top (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           flush,
    input  logic                           dec_valid,
    input  issue_pkg::slot_t               dec_slot0,
    input  issue_pkg::slot_t               dec_slot1,
    output logic                           dec_allowin,
    output logic                           iss_valid0,
    output issue_pkg::slot_t               iss_slot0,
    output logic                           iss_valid1,
    output issue_pkg::slot_t               iss_slot1,
    input  logic                           iss_allowin,
    input  logic                           cfg_req,
    input  logic                           cfg_we,
    input  ctrl_pkg::cfg_addr_e            cfg_addr,
    input  logic [ctrl_pkg::cnt_width-1:0] cfg_wdata,
    output logic                           cfg_ack,
    output logic [ctrl_pkg::cnt_width-1:0] cfg_rdata
);

    logic force_single;
    logic bundle_dual;
    logic bundle_single;

    pair_if dec_pair ();
    pair_if held_pair ();

    // decode side onto the interface
    assign dec_pair.valid = dec_valid;
    assign dec_pair.slot0 = dec_slot0;
    assign dec_pair.slot1 = dec_slot1;
    assign dec_allowin    = dec_pair.allowin;

    pair_reg u_pair_reg (
        .clk   (clk),
        .rstn  (rstn),
        .flush (flush),
        .in    (dec_pair),
        .out   (held_pair)
    );

    dual_issue_split u_split (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .force_single  (force_single),
        .iss_allowin   (iss_allowin),
        .held          (held_pair),
        .iss_valid0    (iss_valid0),
        .iss_valid1    (iss_valid1),
        .iss_slot0     (iss_slot0),
        .iss_slot1     (iss_slot1),
        .bundle_dual   (bundle_dual),
        .bundle_single (bundle_single)
    );

    issue_ctrl_regs u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .bundle_dual   (bundle_dual),
        .bundle_single (bundle_single),
        .cfg_req       (cfg_req),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_ack       (cfg_ack),
        .cfg_rdata     (cfg_rdata),
        .force_single  (force_single)
    );

endmodule

/* bench/issue_assertions.sv */
// issue stage protocol assertions
module issue_assertions (
    input logic             clk,
    input logic             rstn,
    input logic             flush,
    input logic             iss_allowin,
    input logic             iss_valid0,
    input logic             iss_valid1,
    input issue_pkg::slot_t iss_slot0,
    input issue_pkg::slot_t iss_slot1,
    input logic             cfg_req,
    input logic             cfg_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // lane 1 only alongside lane 0
    lane1_needs_lane0: assert property (@(posedge clk) disable iff (!rstn)
        iss_valid1 |-> iss_valid0)
        else $error("lane 1 valid without lane 0");

    // back-pressure holds the lanes unless a flush drops them
    lanes_hold: assert property (@(posedge clk) disable iff (!rstn)
        (iss_valid0 && !iss_allowin) |=> flush ||
        ($stable(iss_valid0) && $stable(iss_valid1) &&
         $stable(iss_slot0) && $stable(iss_slot1)))
        else $error("lane outputs changed while stalled");

    ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(cfg_ack) |-> $past(cfg_req))
        else $error("cfg_ack rose without a request");

endmodule

/* bench/issue_tb.sv */
// dual issue stage testbench
module issue_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic             v1;
        issue_pkg::slot_t s0;
        issue_pkg::slot_t s1;
    } bundle_t;

    localparam int phase_a_cycles = 400;
    localparam int phase_b_cycles = 200;
    // up to one pair per cycle, four cycles each, plus margin for reset and host accesses
    localparam int watchdog_ns = (phase_a_cycles + phase_b_cycles) * 4 * 10 + 2000;

    logic                           clk;
    logic                           rstn;
    logic                           flush;
    logic                           dec_valid;
    issue_pkg::slot_t               dec_slot0;
    issue_pkg::slot_t               dec_slot1;
    logic                           dec_allowin;
    logic                           iss_valid0;
    issue_pkg::slot_t               iss_slot0;
    logic                           iss_valid1;
    issue_pkg::slot_t               iss_slot1;
    logic                           iss_allowin;
    logic                           cfg_req;
    logic                           cfg_we;
    ctrl_pkg::cfg_addr_e            cfg_addr;
    logic [ctrl_pkg::cnt_width-1:0] cfg_wdata;
    logic                           cfg_ack;
    logic [ctrl_pkg::cnt_width-1:0] cfg_rdata;

    logic [31:0] lfsr = 32'hfe007851;
    bundle_t     exp_q[$];
    bit          model_single;
    int          n_dual;
    int          n_single;
    logic [ctrl_pkg::cnt_width-1:0] rd;

    issue_top dut (.*);

    bind issue_top issue_assertions u_assertions (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .iss_allowin (iss_allowin),
        .iss_valid0  (iss_valid0),
        .iss_valid1  (iss_valid1),
        .iss_slot0   (iss_slot0),
        .iss_slot1   (iss_slot1),
        .cfg_req     (cfg_req),
        .cfg_ack     (cfg_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        abort_run("timeout, the run did not finish in the expected time");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [83:0] got,
                                   input logic [83:0] exp);
        abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic issue_pkg::slot_t rand_slot();
        issue_pkg::slot_t s;
        logic [3:0]       op_bits;
        op_bits      = 4'(rand_bits(4));
        s.pc         = rand_bits(32);
        s.op         = (op_bits < 10) ? issue_pkg::opcode_e'(op_bits) : issue_pkg::op_add;
        s.rd         = 5'(rand_bits(2)); // small indices, frequent hazards
        s.rj         = 5'(rand_bits(2));
        s.rk         = 5'(rand_bits(2));
        s.imm        = rand_bits(32);
        s.excp       = (rand_bits(4) == 0);
        s.pred_taken = 1'(rand_bits(1));
        return s;
    endfunction

    // expected bundles of one accepted pair
    task automatic push_pair(input issue_pkg::slot_t a, input issue_pkg::slot_t b);
        logic raw;
        logic both_alu;
        raw      = (a.rd != 5'd0) && (b.rj == a.rd || b.rk == a.rd);
        both_alu = (a.op inside {issue_pkg::op_add, issue_pkg::op_sub,
                                 issue_pkg::op_or, issue_pkg::op_and}) &&
                   (b.op inside {issue_pkg::op_add, issue_pkg::op_sub,
                                 issue_pkg::op_or, issue_pkg::op_and});
        if (a.op == issue_pkg::op_branch && a.pred_taken) begin
            exp_q.push_back('{1'b0, a, issue_pkg::nop_slot}); // wrong path dropped
        end else if (both_alu && !a.excp && !b.excp && !raw && !model_single) begin
            exp_q.push_back('{1'b1, a, b});
        end else begin
            exp_q.push_back('{1'b0, a, issue_pkg::nop_slot});
            exp_q.push_back('{1'b0, b, issue_pkg::nop_slot});
        end
    endtask

    // what transfers at the coming rising edge
    task automatic observe();
        bundle_t e;
        logic    exp_v0;
        logic    exp_ai;
        // a pair is held exactly while its bundles are pending
        exp_v0 = !flush && (exp_q.size() != 0);
        exp_ai = !flush && (exp_q.size() == 0 || (iss_allowin && exp_q.size() == 1));
        assert (iss_valid0 == exp_v0)
            else report_mismatch("iss_valid0", iss_valid0, exp_v0);
        assert (dec_allowin == exp_ai)
            else report_mismatch("dec_allowin", dec_allowin, exp_ai);
        if (flush) begin
            exp_q.delete();
        end else begin
            if (iss_valid0 && iss_allowin) begin
                assert (exp_q.size() > 0) else abort_run("a bundle issued with no pair pending");
                e = exp_q.pop_front();
                assert (iss_valid1 == e.v1) else report_mismatch("iss_valid1", iss_valid1, e.v1);
                assert (iss_slot0 == e.s0) else report_mismatch("iss_slot0", iss_slot0, e.s0);
                assert (iss_slot1 == e.s1) else report_mismatch("iss_slot1", iss_slot1, e.s1);
                if (e.v1) n_dual++;
                else n_single++;
            end
            if (dec_valid && dec_allowin) begin
                assert (exp_q.size() == 0)
                    else abort_run("a new pair was accepted while the previous pair was pending");
                push_pair(dec_slot0, dec_slot1);
            end
        end
    endtask

    task automatic drive_cycle(input logic dv, input logic ia, input logic fl);
        @(negedge clk);
        dec_valid   = dv;
        dec_slot0   = rand_slot();
        dec_slot1   = rand_slot();
        iss_allowin = ia;
        flush       = fl;
        #2;
        observe();
    endtask

    task automatic stim_cycle();
        logic dv;
        logic ia;
        logic fl;
        dv = (rand_bits(2) != 0);
        ia = (rand_bits(2) != 0);
        fl = (rand_bits(5) == 0); // rare flush
        drive_cycle(dv, ia, fl);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) drive_cycle(1'b0, 1'b1, 1'b0);
        drive_cycle(1'b0, 1'b1, 1'b0);
    endtask

    // four-phase host access
    task automatic cfg_access(input logic we, input ctrl_pkg::cfg_addr_e addr,
                              input logic [ctrl_pkg::cnt_width-1:0] wdata,
                              output logic [ctrl_pkg::cnt_width-1:0] rdata);
        @(negedge clk);
        cfg_we    = we;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        cfg_req   = 1'b1;
        do @(negedge clk); while (!cfg_ack);
        rdata   = cfg_rdata;
        cfg_req = 1'b0;
        do @(negedge clk); while (cfg_ack);
    endtask

    initial begin
        rstn        = 1'b0;
        flush       = 1'b0;
        dec_valid   = 1'b0;
        dec_slot0   = issue_pkg::nop_slot;
        dec_slot1   = issue_pkg::nop_slot;
        iss_allowin = 1'b0;
        cfg_req     = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = ctrl_pkg::addr_mode;
        cfg_wdata   = '0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        #2;
        assert (dec_allowin) else report_mismatch("dec_allowin", dec_allowin, 1);
        assert (!iss_valid0) else report_mismatch("iss_valid0", iss_valid0, 0);
        assert (!iss_valid1) else report_mismatch("iss_valid1", iss_valid1, 0);
        assert (!cfg_ack) else report_mismatch("cfg_ack", cfg_ack, 0);
        cfg_access(1'b0, ctrl_pkg::addr_mode, '0, rd);
        assert (rd == 0) else report_mismatch("cfg_rdata", rd, 0);

        repeat (phase_a_cycles) stim_cycle();
        drain();

        cfg_access(1'b1, ctrl_pkg::addr_mode, 16'd1, rd);
        model_single = 1'b1;
        cfg_access(1'b0, ctrl_pkg::addr_mode, '0, rd);
        assert (rd == 1) else report_mismatch("cfg_rdata", rd, 1);
        repeat (phase_b_cycles) stim_cycle();
        drain();

        cfg_access(1'b0, ctrl_pkg::addr_dual_cnt, '0, rd);
        assert (rd == n_dual) else report_mismatch("dual_cnt", rd, n_dual);
        cfg_access(1'b0, ctrl_pkg::addr_single_cnt, '0, rd);
        assert (rd == n_single) else report_mismatch("single_cnt", rd, n_single);

        $display("Verification passed");
        $finish;
    end

endmodule

/* verilog.f */
common/issue_pkg.sv
common/ctrl_pkg.sv
common/pair_if.sv
issue/pair_reg.sv
issue/dual_issue_split.sv
issue/issue_ctrl_regs.sv
source/issue_top.sv
bench/issue_assertions.sv
bench/issue_tb.sv

/* Bender.yml */
package:
  name: dual_issue

sources:
  - common/issue_pkg.sv
  - common/ctrl_pkg.sv
  - common/pair_if.sv
  - issue/pair_reg.sv
  - issue/dual_issue_split.sv
  - issue/issue_ctrl_regs.sv
  - source/issue_top.sv
  - target: test
    files:
      - bench/issue_assertions.sv
      - bench/issue_tb.sv
